/* spi_bus_pkg.sv */
// spi bus widths
// byte and register address sizes shared by the
// peripheral, the selector and the registers

package spi_bus_pkg;

    // one SPI transfer unit, MSB first
    parameter int byte_width = 8;

    // first byte of a transaction carries the register address
    parameter int address_width = 8;

endpackage

/* register_map_pkg.sv */
// register map
// addresses of the readable registers on the SPI bus,
// the fixed chip id and the version text

package register_map_pkg;

    import spi_bus_pkg::*;

    // register addresses
    parameter logic [address_width-1:0] chip_id_address = 8'hdb;
    parameter logic [address_width-1:0] version_address = 8'hb5;
    parameter logic [address_width-1:0] scratch_address = 8'h20;

    // selector state when no known register is addressed
    parameter logic [address_width-1:0] select_none = 8'h00;

    // identification byte returned by the chip id register
    parameter logic [byte_width-1:0] chip_id_value = 8'h81;

    // version text, first character in the top byte
    parameter int version_length = 8;
    parameter logic [version_length*byte_width-1:0] version_text = "FRAME001";

endpackage

/* spi_peripheral.sv */
// spi peripheral
// mode 0 SPI target sampled by the system clock. Synchronizes the pins,
// counts bits, shifts bytes in on rising edges and out on falling edges.
// The first byte of a transaction is passed on as the register address,
// later bytes as data. A reply load drives its MSB straight away.

`timescale 1ns/1ps

module spi_peripheral
    import spi_bus_pkg::*;
#(
    parameter int sync_stages = 2
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     spi_select_in,
    input  logic                     spi_clock_in,
    input  logic                     spi_data_in,
    output logic                     spi_data_out,
    output logic [address_width-1:0] subperipheral_address,
    output logic                     subperipheral_address_valid,
    output logic [byte_width-1:0]    subperipheral_copi,
    output logic                     subperipheral_copi_valid,
    input  logic [byte_width-1:0]    subperipheral_cipo,
    input  logic                     subperipheral_cipo_valid,
    output logic                     transaction_active
);

    localparam int count_width = $clog2(byte_width);
    localparam logic [count_width-1:0] last_bit = count_width'(byte_width - 1);

    logic [sync_stages-1:0] select_sync;
    logic [sync_stages-1:0] sclk_sync;
    logic [sync_stages-1:0] copi_sync;
    logic                   sclk_prev;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic [count_width-1:0] bit_count;
    logic                   first_byte;
    logic [byte_width-1:0]  rx_shift;
    logic [byte_width-1:0]  rx_byte;
    logic [byte_width-1:0]  tx_shift;

    // pin synchronizers, select idles high and clock idles low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            select_sync <= '1;
            sclk_sync <= '0;
            copi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            select_sync <= {select_sync[sync_stages-2:0], spi_select_in};
            sclk_sync <= {sclk_sync[sync_stages-2:0], spi_clock_in};
            copi_sync <= {copi_sync[sync_stages-2:0], spi_data_in};
            sclk_prev <= sclk_sync[sync_stages-1];
        end
    end

    assign sclk_rise = sclk_sync[sync_stages-1] && !sclk_prev;
    assign sclk_fall = !sclk_sync[sync_stages-1] && sclk_prev;
    assign transaction_active = !select_sync[sync_stages-1];

    // byte as it stands once the current bit is shifted in
    assign rx_byte = {rx_shift[byte_width-2:0], copi_sync[sync_stages-1]};

    // bit counting and the per-byte strobes
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_count <= '0;
            first_byte <= 1'b1;
            subperipheral_address_valid <= 1'b0;
            subperipheral_copi_valid <= 1'b0;
        end else begin
            subperipheral_address_valid <= 1'b0;
            subperipheral_copi_valid <= 1'b0;
            if (!transaction_active) begin
                bit_count <= '0;
                first_byte <= 1'b1;
            end else if (sclk_rise) begin
                if (bit_count == last_bit) begin
                    bit_count <= '0;
                    first_byte <= 1'b0;
                    subperipheral_address_valid <= first_byte;
                    subperipheral_copi_valid <= !first_byte;
                end else begin
                    bit_count <= bit_count + 1'b1;
                end
            end
        end
    end

    // receive shifter and the completed bytes
    always_ff @(posedge clock) begin
        if (transaction_active && sclk_rise) begin
            rx_shift <= rx_byte;
            if (bit_count == last_bit) begin
                if (first_byte) begin
                    subperipheral_address <= rx_byte;
                end else begin
                    subperipheral_copi <= rx_byte;
                end
            end
        end
    end

    // transmit shifter
    // count is already back at zero on the falling edge that closes a byte
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tx_shift <= '0;
        end else if (subperipheral_cipo_valid) begin
            tx_shift <= subperipheral_cipo;
        end else if (transaction_active && sclk_fall && bit_count != '0) begin
            tx_shift <= {tx_shift[byte_width-2:0], 1'b0};
        end
    end

    assign spi_data_out = tx_shift[byte_width-1];

    // one byte cannot be both the address and data
    assert property (@(posedge clock) disable iff (!arst_n)
        !(subperipheral_address_valid && subperipheral_copi_valid));

endmodule

/* spi_subperipheral_selector.sv */
// spi subperipheral selector
// holds the register address of the running transaction, enables the
// matching register and forwards that register's reply to the peripheral.
// Unknown addresses select nothing and produce no reply.

`timescale 1ns/1ps

module spi_subperipheral_selector
    import spi_bus_pkg::*;
    import register_map_pkg::*;
(
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [address_width-1:0] subperipheral_address,
    input  logic                     subperipheral_address_valid,
    input  logic                     transaction_active,
    input  logic [byte_width-1:0]    chip_id_data,
    input  logic                     chip_id_data_valid,
    input  logic [byte_width-1:0]    version_data,
    input  logic                     version_data_valid,
    input  logic [byte_width-1:0]    scratch_data,
    input  logic                     scratch_data_valid,
    output logic                     chip_id_enable,
    output logic                     version_enable,
    output logic                     scratch_enable,
    output logic [byte_width-1:0]    subperipheral_cipo,
    output logic                     subperipheral_cipo_valid
);

    logic [address_width-1:0] selected;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            selected <= select_none;
        end else if (!transaction_active) begin
            selected <= select_none;
        end else if (subperipheral_address_valid) begin
            case (subperipheral_address)
                chip_id_address, version_address, scratch_address: begin
                    selected <= subperipheral_address;
                end
                default: selected <= select_none;
            endcase
        end
    end

    assign chip_id_enable = (selected == chip_id_address);
    assign version_enable = (selected == version_address);
    assign scratch_enable = (selected == scratch_address);

    // reply mux, nothing selected means no load
    always_comb begin
        subperipheral_cipo = '0;
        subperipheral_cipo_valid = 1'b0;
        if (chip_id_enable) begin
            subperipheral_cipo = chip_id_data;
            subperipheral_cipo_valid = chip_id_data_valid;
        end else if (version_enable) begin
            subperipheral_cipo = version_data;
            subperipheral_cipo_valid = version_data_valid;
        end else if (scratch_enable) begin
            subperipheral_cipo = scratch_data;
            subperipheral_cipo_valid = scratch_data_valid;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0({chip_id_enable, version_enable, scratch_enable}));

endmodule

/* spi_register_chip_id.sv */
// chip id register
// answers once with the fixed identification byte
// in the cycle after it is selected

`timescale 1ns/1ps

module spi_register_chip_id
    import spi_bus_pkg::*;
    import register_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  enable,
    output logic [byte_width-1:0] data_out,
    output logic                  data_out_valid
);

    logic enable_prev;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable_prev <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            enable_prev <= enable;
            // single pulse on selection
            data_out_valid <= enable && !enable_prev;
        end
    end

    assign data_out = chip_id_value;

endmodule

/* spi_register_version_string.sv */
// version string register
// streams the version text one byte per host byte. Selection restarts
// at the first character, each further host byte moves to the next one.
// Past the end of the text the reply is zero.

`timescale 1ns/1ps

module spi_register_version_string
    import spi_bus_pkg::*;
    import register_map_pkg::*;
#(
    parameter int text_length = version_length
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  data_in_valid,
    output logic [byte_width-1:0] data_out,
    output logic                  data_out_valid
);

    localparam int index_width = $clog2(text_length + 1);

    logic                   enable_prev;
    logic [index_width-1:0] index;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable_prev <= 1'b0;
            index <= '0;
            data_out_valid <= 1'b0;
        end else begin
            enable_prev <= enable;
            data_out_valid <= 1'b0;
            if (enable && !enable_prev) begin
                index <= '0;
                data_out_valid <= 1'b1;
            end else if (enable && data_in_valid) begin
                // stop at the end so the reply stays zero
                if (index < text_length) begin
                    index <= index + 1'b1;
                end
                data_out_valid <= 1'b1;
            end
        end
    end

    // character lookup, first character sits in the top byte
    always_comb begin
        data_out = '0;
        if (index < text_length) begin
            data_out = version_text[(version_length - 1 - index) * byte_width +: byte_width];
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) index <= text_length);

endmodule

/* spi_register_scratch.sv */
// scratch register
// one byte the host can write and read back. Selection replies with
// the stored byte, each following host byte overwrites it.

`timescale 1ns/1ps

module spi_register_scratch
    import spi_bus_pkg::*;
    import register_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [byte_width-1:0] data_in,
    input  logic                  data_in_valid,
    output logic [byte_width-1:0] data_out,
    output logic                  data_out_valid
);

    logic                  enable_prev;
    logic [byte_width-1:0] stored;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable_prev <= 1'b0;
            data_out_valid <= 1'b0;
            stored <= '0;
        end else begin
            enable_prev <= enable;
            // reply only on selection, writes are silent
            data_out_valid <= enable && !enable_prev;
            if (enable && data_in_valid) begin
                stored <= data_in;
            end
        end
    end

    assign data_out = stored;

endmodule

/* spi_top.sv */
// spi register block
// SPI peripheral with its address selector and the chip id,
// version string and scratch registers

`timescale 1ns/1ps

module spi_top
    import spi_bus_pkg::*;
    import register_map_pkg::*;
#(
    parameter int sync_stages = 2,
    parameter int text_length = version_length
) (
    input  logic clock,
    input  logic arst_n,
    input  logic spi_select_in,
    input  logic spi_clock_in,
    input  logic spi_data_in,
    output logic spi_data_out
);

    logic [address_width-1:0] subperipheral_address;
    logic                     subperipheral_address_valid;
    logic [byte_width-1:0]    subperipheral_copi;
    logic                     subperipheral_copi_valid;
    logic [byte_width-1:0]    subperipheral_cipo;
    logic                     subperipheral_cipo_valid;
    logic                     transaction_active;

    logic                     chip_id_enable;
    logic [byte_width-1:0]    chip_id_data;
    logic                     chip_id_data_valid;
    logic                     version_enable;
    logic [byte_width-1:0]    version_data;
    logic                     version_data_valid;
    logic                     scratch_enable;
    logic [byte_width-1:0]    scratch_data;
    logic                     scratch_data_valid;

    spi_peripheral #(
        .sync_stages(sync_stages)
    ) spi_peripheral (
        .clock(clock),
        .arst_n(arst_n),
        .spi_select_in(spi_select_in),
        .spi_clock_in(spi_clock_in),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .subperipheral_address(subperipheral_address),
        .subperipheral_address_valid(subperipheral_address_valid),
        .subperipheral_copi(subperipheral_copi),
        .subperipheral_copi_valid(subperipheral_copi_valid),
        .subperipheral_cipo(subperipheral_cipo),
        .subperipheral_cipo_valid(subperipheral_cipo_valid),
        .transaction_active(transaction_active)
    );

    spi_subperipheral_selector spi_subperipheral_selector (
        .clock(clock),
        .arst_n(arst_n),
        .subperipheral_address(subperipheral_address),
        .subperipheral_address_valid(subperipheral_address_valid),
        .transaction_active(transaction_active),
        .chip_id_data(chip_id_data),
        .chip_id_data_valid(chip_id_data_valid),
        .version_data(version_data),
        .version_data_valid(version_data_valid),
        .scratch_data(scratch_data),
        .scratch_data_valid(scratch_data_valid),
        .chip_id_enable(chip_id_enable),
        .version_enable(version_enable),
        .scratch_enable(scratch_enable),
        .subperipheral_cipo(subperipheral_cipo),
        .subperipheral_cipo_valid(subperipheral_cipo_valid)
    );

    spi_register_chip_id spi_register_chip_id (
        .clock(clock),
        .arst_n(arst_n),
        .enable(chip_id_enable),
        .data_out(chip_id_data),
        .data_out_valid(chip_id_data_valid)
    );

    spi_register_version_string #(
        .text_length(text_length)
    ) spi_register_version_string (
        .clock(clock),
        .arst_n(arst_n),
        .enable(version_enable),
        .data_in_valid(subperipheral_copi_valid),
        .data_out(version_data),
        .data_out_valid(version_data_valid)
    );

    spi_register_scratch spi_register_scratch (
        .clock(clock),
        .arst_n(arst_n),
        .enable(scratch_enable),
        .data_in(subperipheral_copi),
        .data_in_valid(subperipheral_copi_valid),
        .data_out(scratch_data),
        .data_out_valid(scratch_data_valid)
    );

endmodule

/* tb_spi_checker.sv */
// spi reply checker
// watches the SPI pins of the register block, rebuilds each reply byte
// from spi_data_out on rising SPI clock edges and compares it with the
// expected bytes of the trace

`timescale 1ns/1ps

module tb_spi_checker #(
    parameter int trace_depth = 256
) (
    input  logic clock,
    input  logic arst_n,
    input  logic spi_select_in,
    input  logic spi_clock_in,
    input  logic spi_data_out,
    input  logic end_of_test,
    output int   error_count
);

    logic [7:0] trace [0:trace_depth-1];
    logic [7:0] rx_byte;
    logic       select_prev;
    logic       sclk_prev;
    logic       in_transaction;
    logic       ended;
    int         trace_pos;
    int         transaction_index;
    int         byte_index;
    int         bit_index;

    initial begin
        $readmemh("spi_trace.txt", trace);
    end

    task start_transaction();
        in_transaction = (trace[trace_pos] != 8'h00);
        if (!in_transaction) begin
            $display("error at %0d ns: transaction %0d is not in the trace",
                     $time, transaction_index);
            error_count++;
        end
        byte_index = 0;
        bit_index = 0;
    endtask

    task compare_byte();
        int count;
        logic [7:0] expected;
        count = trace[trace_pos];
        if (byte_index >= count) begin
            $display("error at %0d ns: transaction %0d has more bytes than the trace",
                     $time, transaction_index);
            error_count++;
        end else begin
            expected = trace[trace_pos + 1 + count + byte_index];
            if (rx_byte !== expected) begin
                $display("FAILED at %0d ns: spi_data_out expected %02h got %02h",
                         $time, expected, rx_byte);
                $display("    in transaction %0d, byte %0d", transaction_index, byte_index);
                error_count++;
            end
        end
        byte_index++;
        bit_index = 0;
    endtask

    task end_transaction();
        int count;
        count = trace[trace_pos];
        if (in_transaction) begin
            if (bit_index != 0 || byte_index < count) begin
                $display("error at %0d ns: transaction %0d ended after %0d of %0d bytes",
                         $time, transaction_index, byte_index, count);
                error_count++;
            end
            trace_pos = trace_pos + 1 + 2 * count;
        end
        transaction_index++;
        in_transaction = 1'b0;
    endtask

    always @(posedge clock) begin
        if (!arst_n) begin
            select_prev = 1'b1;
            sclk_prev = 1'b0;
            in_transaction = 1'b0;
            ended = 1'b0;
            rx_byte = 8'h00;
            trace_pos = 0;
            transaction_index = 0;
            byte_index = 0;
            bit_index = 0;
            error_count = 0;
        end else begin
            if (select_prev && !spi_select_in) begin
                start_transaction();
            end else if (!select_prev && spi_select_in) begin
                end_transaction();
            end else if (in_transaction && !spi_select_in && spi_clock_in && !sclk_prev) begin
                // host samples on the rising SPI clock edge
                rx_byte = {rx_byte[6:0], spi_data_out};
                bit_index++;
                if (bit_index == 8) begin
                    compare_byte();
                end
            end
            if (end_of_test && !ended) begin
                ended = 1'b1;
                if (trace[trace_pos] != 8'h00) begin
                    $display("error: trace transactions from number %0d on were never seen",
                             transaction_index);
                    error_count++;
                end
            end
            select_prev = spi_select_in;
            sclk_prev = spi_clock_in;
        end
    end

endmodule

/* tb_spi_top.sv */
// spi register block testbench
// drives SPI mode 0 transactions from the trace onto the register block,
// one bit per SPI clock period of 12 system clocks, with a random idle gap
// between transactions. Reply bytes are checked by tb_spi_checker.

`timescale 1ns/1ps

module tb_spi_top;

    localparam int half_period = 6;
    localparam int byte_gap = 4;
    localparam int trace_depth = 256;

    logic       clock;
    logic       arst_n;
    logic       spi_select_in;
    logic       spi_clock_in;
    logic       spi_data_in;
    logic       spi_data_out;
    logic       end_of_test;
    int         error_count;
    int         total_bytes;
    int         timeout_limit = 0;
    int         cycle_count = 0;
    logic [7:0] trace [0:trace_depth-1];

    spi_top #(
        .sync_stages(2),
        .text_length(8)
    ) dut0 (
        .clock(clock),
        .arst_n(arst_n),
        .spi_select_in(spi_select_in),
        .spi_clock_in(spi_clock_in),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out)
    );

    tb_spi_checker #(
        .trace_depth(trace_depth)
    ) checker0 (
        .clock(clock),
        .arst_n(arst_n),
        .spi_select_in(spi_select_in),
        .spi_clock_in(spi_clock_in),
        .spi_data_out(spi_data_out),
        .end_of_test(end_of_test),
        .error_count(error_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    // MSB first with data set up half a period before the rising edge
    task automatic send_byte(input logic [7:0] value);
        int i;
        for (i = 7; i >= 0; i--) begin
            spi_data_in <= value[i];
            wait_cycles(half_period);
            spi_clock_in <= 1'b1;
            wait_cycles(half_period);
            spi_clock_in <= 1'b0;
        end
    endtask

    // one trace line holds the count byte at pos and then the host bytes
    task automatic run_transaction(input int pos);
        int count;
        int k;
        count = trace[pos];
        spi_select_in <= 1'b0;
        wait_cycles(half_period);
        for (k = 0; k < count; k++) begin
            send_byte(trace[pos + 1 + k]);
            wait_cycles(byte_gap);
        end
        wait_cycles(half_period);
        spi_select_in <= 1'b1;
        wait_cycles(12 + int'($urandom % 24));
    endtask

    // sum of the byte counts for the timeout
    function automatic int count_trace_bytes();
        int pos;
        int sum;
        pos = 0;
        sum = 0;
        while (pos < trace_depth && trace[pos] != 8'h00) begin
            sum = sum + trace[pos];
            pos = pos + 1 + 2 * trace[pos];
        end
        return sum;
    endfunction

    initial begin
        int pos;
        arst_n <= 1'b0;
        spi_select_in <= 1'b1;
        spi_clock_in <= 1'b0;
        spi_data_in <= 1'b0;
        end_of_test <= 1'b0;
        void'($urandom(33));
        $readmemh("spi_trace.txt", trace);
        total_bytes = count_trace_bytes();
        timeout_limit = total_bytes * 120 + 2000;
        wait_cycles(8);
        arst_n <= 1'b1;
        wait_cycles(4);
        pos = 0;
        while (trace[pos] != 8'h00) begin
            run_transaction(pos);
            pos = pos + 1 + 2 * trace[pos];
        end
        end_of_test <= 1'b1;
        wait_cycles(3);
        $display("trace bytes: %0d, errors: %0d", total_bytes, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, the trace did not complete", cycle_count);
            $display("trace bytes: %0d, errors: %0d", total_bytes, error_count + 1);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

/* spi_trace.txt */
// columns: byte count, host bytes, expected reply bytes on spi_data_out
// one transaction per line, a count of 00 ends the trace
// scratch after reset reads 00, the host byte a4 is stored
02  20 a4  00 00
// scratch returns a4, then three writes leave c6
04  20 11 22 c6  00 a4 00 00
// scratch read back, host byte 00 overwrites it
02  20 00  00 c6
// unknown address, no reply
03  7e 12 34  00 00 00
// chip id, its last bit stays in the shifter for one more byte
04  db 00 00 00  00 81 80 00
// version text, zero once past the end
0a  b5 00 00 00 00 00 00 00 00 00  00 46 52 41 4d 45 30 30 31 00
// scratch still 00 after the other registers, stores 5a
02  20 5a  00 00
02  20 00  00 5a
00

/* filelist.f */
spi_bus_pkg.sv
register_map_pkg.sv
spi_peripheral.sv
spi_subperipheral_selector.sv
spi_register_chip_id.sv
spi_register_version_string.sv
spi_register_scratch.sv
spi_top.sv
tb_spi_checker.sv
tb_spi_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the SPI register block testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_top -f filelist.f -o tb_spi_top_sim

./obj_dir/tb_spi_top_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
